//--- source/snes_pkg.sv
`default_nettype none

package snes_pkg;

	// pulse half period in clocks, latch lasts two half periods
	localparam int snes_half_cycles = 3;
	localparam int snes_frame_bits = 16;
	localparam int snes_button_bits = 12;

	localparam int snes_cnt_w = $clog2(2 * snes_half_cycles);
	localparam int snes_bit_w = $clog2(snes_frame_bits);

	localparam logic [snes_cnt_w-1:0] snes_latch_last = snes_cnt_w'(2 * snes_half_cycles - 1);
	localparam logic [snes_cnt_w-1:0] snes_half_last = snes_cnt_w'(snes_half_cycles - 1);
	localparam logic [snes_bit_w-1:0] snes_bit_last = snes_bit_w'(snes_frame_bits - 1);

	// listed msb first, so b lands on bit 0 as the first bit shifted in
	typedef struct packed {
		logic r;
		logic l;
		logic x;
		logic a;
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic y;
		logic b;
	} snes_buttons_t;

	typedef union packed {
		logic [snes_button_bits-1:0] raw;
		snes_buttons_t buttons;
	} snes_pad_u;

	typedef struct packed {
		snes_pad_u pad;
		logic present;
		logic valid;
	} snes_result_t;

endpackage

`default_nettype wire

//--- source/apb_pkg.sv
`default_nettype none

package apb_pkg;

	localparam int apb_addr_w = 5;
	localparam int apb_data_w = 32;

	localparam logic [apb_addr_w-1:0] reg_status = 5'h00;
	localparam logic [apb_addr_w-1:0] reg_ctrl = 5'h04;
	localparam logic [apb_addr_w-1:0] reg_pad_a = 5'h08;
	localparam logic [apb_addr_w-1:0] reg_pad_b = 5'h0C;

	// reg_ctrl fields
	localparam int ctrl_start_bit = 0;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [apb_data_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_w-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic busy;
		logic pause;
		logic present_a;
		logic present_b;
		logic done;
	} status_t;

endpackage

`default_nettype wire

//--- source/snes_cont.sv
`timescale 1ns/1ps
`default_nettype none

module snes_cont (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   poll_start,
	input  logic                   data,
	output logic                   latch,
	output logic                   pulse,
	output snes_pkg::snes_result_t result
);

	typedef enum logic [1:0] {
		st_idle,
		st_latch,
		st_shift
	} state_e;

	state_e state;
	logic [snes_pkg::snes_cnt_w-1:0] cnt;
	logic [snes_pkg::snes_bit_w-1:0] bit_cnt;
	logic [snes_pkg::snes_frame_bits-1:0] frame;
	logic sample;
	logic last_cycle;

	// one sample per bit, on the first cycle of the pulse high phase
	assign sample = (state == st_shift) && pulse && (cnt == '0);

	// end of the low phase after the final pulse
	assign last_cycle = (state == st_shift) && !pulse &&
		(cnt == snes_pkg::snes_half_last) && (bit_cnt == snes_pkg::snes_bit_last);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			latch <= 1'b0;
			pulse <= 1'b0;
			cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (poll_start) begin
						state <= st_latch;
						latch <= 1'b1;
						cnt <= '0;
					end
				end
				st_latch: begin
					if (cnt == snes_pkg::snes_latch_last) begin
						state <= st_shift;
						latch <= 1'b0;
						pulse <= 1'b1;
						cnt <= '0;
						bit_cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_shift: begin
					if (cnt == snes_pkg::snes_half_last) begin
						cnt <= '0;
						if (pulse) begin
							pulse <= 1'b0;
						end else if (bit_cnt == snes_pkg::snes_bit_last) begin
							state <= st_idle;
						end else begin
							pulse <= 1'b1;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// data line is active low, store pressed as 1
	always_ff @(posedge clk) begin
		if (sample) begin
			frame <= {~data, frame[snes_pkg::snes_frame_bits-1:1]};
		end
	end

	always_comb begin
		result.pad.raw = frame[snes_pkg::snes_button_bits-1:0];
		// trailing bits read released on a connected pad
		result.present = ~|frame[snes_pkg::snes_frame_bits-1:snes_pkg::snes_button_bits];
		result.valid = last_cycle;
	end

endmodule

`default_nettype wire

//--- source/input_regs.sv
`timescale 1ns/1ps
`default_nettype none

module input_regs (
	input  logic                   clk,
	input  logic                   arst_n,
	input  apb_pkg::apb_req_t      apb_req,
	output apb_pkg::apb_rsp_t      apb_rsp,
	input  snes_pkg::snes_result_t result_a,
	input  snes_pkg::snes_result_t result_b,
	output logic                   poll_start
);

	localparam int status_pad_w = apb_pkg::apb_data_w - $bits(apb_pkg::status_t);
	localparam int pad_pad_w = apb_pkg::apb_data_w - snes_pkg::snes_button_bits;

	logic access;
	logic wr;
	logic rd;
	logic sel_status;
	logic sel_ctrl;
	logic sel_pad_a;
	logic sel_pad_b;
	logic mapped;
	logic start_req;
	logic bad_access;
	logic ctrl_write;

	apb_pkg::status_t status;
	snes_pkg::snes_pad_u pad_a;
	snes_pkg::snes_pad_u pad_b;

	assign access = apb_req.psel & apb_req.penable;
	assign wr = access & apb_req.pwrite;
	assign rd = access & ~apb_req.pwrite;

	assign sel_status = (apb_req.paddr == apb_pkg::reg_status);
	assign sel_ctrl = (apb_req.paddr == apb_pkg::reg_ctrl);
	assign sel_pad_a = (apb_req.paddr == apb_pkg::reg_pad_a);
	assign sel_pad_b = (apb_req.paddr == apb_pkg::reg_pad_b);
	assign mapped = sel_status | sel_ctrl | sel_pad_a | sel_pad_b;

	assign start_req = wr & sel_ctrl & apb_req.pwdata[apb_pkg::ctrl_start_bit];

	assign bad_access = access & (~mapped | (rd & sel_ctrl) |
		(wr & (sel_status | sel_pad_a | sel_pad_b)) | (start_req & status.busy));

	// a rejected write has no side effect
	assign ctrl_write = wr & sel_ctrl & ~bad_access;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			poll_start <= 1'b0;
			status <= '0;
			pad_a <= '0;
			pad_b <= '0;
		end else begin
			poll_start <= ctrl_write & apb_req.pwdata[apb_pkg::ctrl_start_bit];
			if (poll_start) begin
				status.busy <= 1'b1;
			end
			if (ctrl_write) begin
				status.done <= 1'b0;
			end
			// both readers run in lockstep, pad a's strobe covers both
			if (result_a.valid) begin
				status.busy <= 1'b0;
				status.done <= 1'b1;
				status.pause <= result_a.pad.buttons.start | result_b.pad.buttons.start;
				status.present_a <= result_a.present;
				status.present_b <= result_b.present;
				pad_a <= result_a.pad;
				pad_b <= result_b.pad;
			end
		end
	end

	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = bad_access;
		apb_rsp.prdata = '0;
		if (sel_status) begin
			apb_rsp.prdata = {{status_pad_w{1'b0}}, status};
		end else if (sel_pad_a) begin
			apb_rsp.prdata = {{pad_pad_w{1'b0}}, pad_a.raw};
		end else if (sel_pad_b) begin
			apb_rsp.prdata = {{pad_pad_w{1'b0}}, pad_b.raw};
		end
	end

endmodule

`default_nettype wire

//--- source/game_input.sv
`timescale 1ns/1ps
`default_nettype none

module game_input (
	input  logic              clk,
	input  logic              arst_n,
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input  logic              data_a,
	output logic              latch_a,
	output logic              pulse_a,
	input  logic              data_b,
	output logic              latch_b,
	output logic              pulse_b
);

	logic poll_start;
	snes_pkg::snes_result_t result_a;
	snes_pkg::snes_result_t result_b;

	snes_cont pad_a_i (
		.clk(clk),
		.arst_n(arst_n),
		.poll_start(poll_start),
		.data(data_a),
		.latch(latch_a),
		.pulse(pulse_a),
		.result(result_a)
	);

	snes_cont pad_b_i (
		.clk(clk),
		.arst_n(arst_n),
		.poll_start(poll_start),
		.data(data_b),
		.latch(latch_b),
		.pulse(pulse_b),
		.result(result_b)
	);

	input_regs regs_i (
		.clk(clk),
		.arst_n(arst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.result_a(result_a),
		.result_b(result_b),
		.poll_start(poll_start)
	);

endmodule

`default_nettype wire

//--- verif/game_input_properties.sv
`timescale 1ns/1ps
`default_nettype none

module game_input_properties (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   latch_a,
	input logic                   pulse_a,
	input logic                   latch_b,
	input logic                   pulse_b,
	input logic                   poll_start,
	input snes_pkg::snes_result_t result_a,
	input apb_pkg::apb_req_t      apb_req,
	input apb_pkg::apb_rsp_t      apb_rsp
);

	logic busy;

	// a poll runs from the start strobe to the reader result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (poll_start) begin
			busy <= 1'b1;
		end else if (result_a.valid) begin
			busy <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(latch_a && pulse_a))
		else $error("pad a drives latch and pulse high together");

	assert property (@(posedge clk) disable iff (!arst_n) !(latch_b && pulse_b))
		else $error("pad b drives latch and pulse high together");

	assert property (@(posedge clk) disable iff (!arst_n) poll_start |-> !busy)
		else $error("poll started while a poll was running");

	assert property (@(posedge clk) disable iff (!arst_n)
		!(apb_req.psel && apb_req.penable) |-> !apb_rsp.pslverr)
		else $error("pslverr high outside an access phase");

endmodule

bind game_input game_input_properties props_i (
	.clk(clk),
	.arst_n(arst_n),
	.latch_a(latch_a),
	.pulse_a(pulse_a),
	.latch_b(latch_b),
	.pulse_b(pulse_b),
	.poll_start(poll_start),
	.result_a(result_a),
	.apb_req(apb_req),
	.apb_rsp(apb_rsp)
);

`default_nettype wire

//--- verif/tb_game_input.sv
`timescale 1ns/1ps
`default_nettype none

module pad_model (
	input  logic        latch,
	input  logic        pulse,
	input  logic        disconnect,
	input  logic [15:0] pattern,
	output logic        data
);

	logic [15:0] frame;

	initial begin
		frame = '0;
	end

	always @(negedge latch) begin
		frame <= pattern;
	end

	// released bits follow the frame
	always @(negedge pulse) begin
		frame <= frame >> 1;
	end

	// active low, an unplugged pad pulls the line low
	assign data = disconnect ? 1'b0 : ~frame[0];

endmodule

module tb_game_input;

	logic clk;
	logic arst_n;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	logic data_a;
	logic latch_a;
	logic pulse_a;
	logic data_b;
	logic latch_b;
	logic pulse_b;
	logic [15:0] pattern_a;
	logic [15:0] pattern_b;
	logic disc_a;
	logic disc_b;
	logic [31:0] lfsr;
	int mismatch_count;
	int bus_err_count;
	int timeout_count;

	game_input dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.data_a(data_a),
		.latch_a(latch_a),
		.pulse_a(pulse_a),
		.data_b(data_b),
		.latch_b(latch_b),
		.pulse_b(pulse_b)
	);

	pad_model pad_a_model (
		.latch(latch_a),
		.pulse(pulse_a),
		.disconnect(disc_a),
		.pattern(pattern_a),
		.data(data_a)
	);

	pad_model pad_b_model (
		.latch(latch_b),
		.pulse(pulse_b),
		.disconnect(disc_b),
		.pattern(pattern_b),
		.data(data_b)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [11:0] take_bits(input int n);
		logic [11:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic apb_pkg::status_t to_status(input logic [31:0] rdata);
		return apb_pkg::status_t'(rdata[$bits(apb_pkg::status_t)-1:0]);
	endfunction

	// serial bit i is button i, b comes first
	function automatic snes_pkg::snes_pad_u expect_pad(input logic [15:0] pattern, input logic disc);
		snes_pkg::snes_pad_u pad;
		pad.raw = disc ? 12'hfff : pattern[11:0];
		return pad;
	endfunction

	function automatic logic expect_present(input logic [15:0] pattern, input logic disc);
		return !disc && (pattern[15:12] == 4'h0);
	endfunction

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] wdata, input logic exp_err);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		if (apb_rsp.pready !== 1'b1) begin
			$display("write to 0x%02h saw pready low in the access phase", addr);
			bus_err_count++;
		end
		if (apb_rsp.pslverr !== exp_err) begin
			$display("write to 0x%02h returned pslverr %b where %b was expected",
				addr, apb_rsp.pslverr, exp_err);
			bus_err_count++;
		end
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic apb_read(input logic [4:0] addr, input logic exp_err, output logic [31:0] rdata);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rdata = apb_rsp.prdata;
		if (apb_rsp.pready !== 1'b1) begin
			$display("read of 0x%02h saw pready low in the access phase", addr);
			bus_err_count++;
		end
		if (apb_rsp.pslverr !== exp_err) begin
			$display("read of 0x%02h returned pslverr %b where %b was expected",
				addr, apb_rsp.pslverr, exp_err);
			bus_err_count++;
		end
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic check_pad(input string name, input snes_pkg::snes_pad_u exp,
			input snes_pkg::snes_pad_u act);
		if (act !== exp) begin
			$display("mismatch %s: expected %03h, actual %03h", name, exp.raw, act.raw);
			mismatch_count++;
		end
	endtask

	task automatic check_status(input string name, input apb_pkg::status_t exp,
			input apb_pkg::status_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %05b, actual %05b", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic wait_done();
		logic [31:0] rdata;
		apb_pkg::status_t st;
		int tries;
		tries = 0;
		st = '0;
		while (!st.done && tries < 100) begin
			apb_read(apb_pkg::reg_status, 1'b0, rdata);
			st = to_status(rdata);
			tries++;
		end
		if (!st.done) begin
			$display("poll did not finish");
			timeout_count++;
		end
	endtask

	task automatic load_pads(input logic [15:0] pa, input logic [15:0] pb,
			input logic da, input logic db);
		@(posedge clk);
		pattern_a <= pa;
		pattern_b <= pb;
		disc_a <= da;
		disc_b <= db;
	endtask

	task automatic check_results(input string name, input logic [15:0] pa, input logic [15:0] pb,
			input logic da, input logic db);
		logic [31:0] rdata;
		snes_pkg::snes_pad_u exp_a;
		snes_pkg::snes_pad_u exp_b;
		apb_pkg::status_t exp_st;
		exp_a = expect_pad(pa, da);
		exp_b = expect_pad(pb, db);
		exp_st = '0;
		exp_st.done = 1'b1;
		// start is serial bit 3
		exp_st.pause = exp_a.raw[3] | exp_b.raw[3];
		exp_st.present_a = expect_present(pa, da);
		exp_st.present_b = expect_present(pb, db);
		apb_read(apb_pkg::reg_status, 1'b0, rdata);
		check_status(name, exp_st, to_status(rdata));
		apb_read(apb_pkg::reg_pad_a, 1'b0, rdata);
		check_pad({name, " pad a"}, exp_a, snes_pkg::snes_pad_u'(rdata[11:0]));
		apb_read(apb_pkg::reg_pad_b, 1'b0, rdata);
		check_pad({name, " pad b"}, exp_b, snes_pkg::snes_pad_u'(rdata[11:0]));
	endtask

	task automatic run_poll(input string name, input logic [15:0] pa, input logic [15:0] pb,
			input logic da, input logic db);
		load_pads(pa, pb, da, db);
		apb_write(apb_pkg::reg_ctrl, 32'h1, 1'b0);
		wait_done();
		check_results(name, pa, pb, da, db);
	endtask

	task automatic test_reset();
		logic [31:0] rdata;
		apb_read(apb_pkg::reg_status, 1'b0, rdata);
		check_status("reset", '0, to_status(rdata));
		apb_read(apb_pkg::reg_pad_a, 1'b0, rdata);
		check_pad("reset pad a", '0, snes_pkg::snes_pad_u'(rdata[11:0]));
		apb_read(apb_pkg::reg_pad_b, 1'b0, rdata);
		check_pad("reset pad b", '0, snes_pkg::snes_pad_u'(rdata[11:0]));
	endtask

	task automatic test_pause();
		// start is serial bit 3
		run_poll("pause a", 16'h0008, 16'h0a00, 1'b0, 1'b0);
		run_poll("pause b", 16'h0401, 16'h0009, 1'b0, 1'b0);
		run_poll("pause both", 16'h0808, 16'h0038, 1'b0, 1'b0);
	endtask

	task automatic test_bus_errors();
		logic [31:0] rdata;
		apb_read(5'h10, 1'b1, rdata);
		apb_write(5'h14, 32'h1, 1'b1);
		apb_write(apb_pkg::reg_status, 32'h1, 1'b1);
		apb_write(apb_pkg::reg_pad_b, 32'h1, 1'b1);
		apb_read(apb_pkg::reg_ctrl, 1'b1, rdata);
		load_pads(16'h0321, 16'h0654, 1'b0, 1'b0);
		apb_write(apb_pkg::reg_ctrl, 32'h1, 1'b0);
		apb_write(apb_pkg::reg_ctrl, 32'h1, 1'b1);
		wait_done();
		check_results("start while busy", 16'h0321, 16'h0654, 1'b0, 1'b0);
	endtask

	task automatic test_random();
		logic [15:0] pa;
		logic [15:0] pb;
		for (int i = 0; i < 10; i++) begin
			pa = '0;
			pb = '0;
			pa[11:0] = take_bits(12);
			pb[11:0] = take_bits(12);
			run_poll($sformatf("random %0d", i), pa, pb, 1'b0, 1'b0);
		end
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		apb_req = '0;
		pattern_a = '0;
		pattern_b = '0;
		disc_a = 1'b0;
		disc_b = 1'b0;
		lfsr = 32'd78942;
		mismatch_count = 0;
		bus_err_count = 0;
		timeout_count = 0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		test_reset();
		run_poll("fixed", 16'h0a53, 16'h0c81, 1'b0, 1'b0);
		test_pause();
		run_poll("disconnect a", 16'h0123, 16'h0456, 1'b1, 1'b0);
		run_poll("disconnect b", 16'h0789, 16'h0ab0, 1'b0, 1'b1);
		test_bus_errors();
		test_random();
		$display("errors: %0d mismatches, %0d bus errors, %0d timeouts",
			mismatch_count, bus_err_count, timeout_count);
		if (mismatch_count + bus_err_count + timeout_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
source/snes_pkg.sv
source/apb_pkg.sv
source/snes_cont.sv
source/input_regs.sv
source/game_input.sv
verif/game_input_properties.sv
verif/tb_game_input.sv

//--- Bender.yml
package:
  name: game_input

sources:
  - target: any(rtl, verif)
    files:
      - source/snes_pkg.sv
      - source/apb_pkg.sv
      - source/snes_cont.sv
      - source/input_regs.sv
      - source/game_input.sv
  - target: verif
    files:
      - verif/game_input_properties.sv
      - verif/tb_game_input.sv
